/* hw/enc_pkg.sv */
/*
 * shared definitions for the quadrature encoder block
 *   sizes, filter length, reset preload and block select
 *   register offset enum
 *   write port bundle and per-channel measurement bundle
 */

package enc_pkg;

    // --------------------
    // sizes and constants
    // --------------------
    localparam int NUM_CHANNELS = 4;                   // encoder channels on the board
    localparam int CH_W         = $clog2(NUM_CHANNELS); // channel index width
    localparam int DEB_CYCLES   = 4;                   // stable cycles before filt follows
    localparam int DEB_CNT_W    = $clog2(DEB_CYCLES + 1);

    localparam logic [23:0] PRELOAD_RESET = 24'h800000; // half scale
    localparam logic [3:0]  ADDR_MAIN     = 4'h4;       // addr[15:12] of this block
    localparam logic [30:0] RUN_MAX       = '1;         // running timer saturation

    // register offset, addr[3:0]
    typedef enum logic [3:0] {
        OFF_ENC_LOAD  = 4'd4,  // preload
        OFF_ENC_DATA  = 4'd5,  // position count
        OFF_PER_DATA  = 4'd6,  // full period
        OFF_QTR1_DATA = 4'd7,  // latest quarter period
        OFF_QTR5_DATA = 4'd8,  // quarter period four edges back
        OFF_RUN_DATA  = 4'd9   // running time
    } reg_offset_e;

    // --------------------
    // bundles
    // --------------------
    // write port from the register file master
    typedef struct packed {
        logic [15:0] waddr;
        logic [31:0] wdata;
        logic        wen;
    } reg_wr_t;

    // velocity results, bit 31 = dir at last edge, 30..0 = sysclk cycles
    typedef struct packed {
        logic [31:0] perd;
        logic [31:0] qtr1;
        logic [31:0] qtr5;
        logic [31:0] run;
    } enc_meas_t;

endpackage

/* hw/enc_debounce.sv */
/*
 * encoder line filter
 *   two-flop synchronizer for the asynchronous input
 *   stability counter, output follows after DEB_CYCLES stable cycles
 */

`timescale 1ns/1ps

module enc_debounce import enc_pkg::*; (
    input  logic sysclk,
    input  logic reset,   // sync, active low
    input  logic raw,     // asynchronous encoder line
    output logic filt     // filtered line
);

    logic                 sync_0;      // first sync stage
    logic                 sync_1;      // second sync stage, safe to use
    logic [DEB_CNT_W-1:0] stable_cnt;  // cycles sync_1 has differed from filt
    logic [DEB_CNT_W-1:0] cnt_next;

    assign cnt_next = stable_cnt + 1'b1;

    always_ff @(posedge sysclk) begin
        if (!reset) begin
            sync_0     <= 1'b0;
            sync_1     <= 1'b0;
            stable_cnt <= '0;
            filt       <= 1'b0;
        end else begin
            sync_0 <= raw;
            sync_1 <= sync_0;

            if (sync_1 == filt) begin
                stable_cnt <= '0;                     // no change pending, glitch dropped
            end else if (cnt_next == DEB_CNT_W'(DEB_CYCLES)) begin
                filt       <= sync_1;                 // held long enough
                stable_cnt <= '0;
            end else begin
                stable_cnt <= cnt_next;
            end
        end
    end

endmodule

/* hw/enc_quad.sv */
/*
 * 4x quadrature decoder
 *   gray-code step detect on the filtered A/B pair
 *   24-bit up/down position count with sticky overflow in bit 24
 *   preload on set, direction of the latest step
 */

`timescale 1ns/1ps

module enc_quad import enc_pkg::*; (
    input  logic        sysclk,
    input  logic        reset,    // sync, active low
    input  logic        a,        // filtered A
    input  logic        b,        // filtered B
    input  logic        set,      // one-cycle preload strobe
    input  logic [23:0] preload,
    output logic [24:0] count,    // bit 24 = overflow/underflow
    output logic        dir       // 1 = forward, A leads B
);

    logic [1:0]  ab_prev;   // pair from last cycle
    logic [1:0]  ab_cur;
    logic        step_up;
    logic        step_dn;
    logic        dir_q;     // direction of last legal step
    logic [24:0] inc_sum;   // bit 24 = carry out
    logic [24:0] dec_diff;  // bit 24 = borrow

    assign ab_cur = {a, b};

    // --------------------
    // step decode
    // --------------------
    // forward sequence 00 -> 10 -> 11 -> 01 -> 00
    always_comb begin
        step_up = 1'b0;
        step_dn = 1'b0;
        case ({ab_prev, ab_cur})
            4'b00_10, 4'b10_11, 4'b11_01, 4'b01_00: step_up = 1'b1;
            4'b00_01, 4'b01_11, 4'b11_10, 4'b10_00: step_dn = 1'b1;
            default: ;  // no move, or illegal double step
        endcase
    end

    // current step direction, so a same-cycle period update sees it
    assign dir = step_up ? 1'b1 : (step_dn ? 1'b0 : dir_q);

    assign inc_sum  = {1'b0, count[23:0]} + 25'd1;
    assign dec_diff = {1'b0, count[23:0]} - 25'd1;

    // --------------------
    // position counter
    // --------------------
    always_ff @(posedge sysclk) begin
        if (!reset) begin
            ab_prev <= 2'b00;                   // matches filter reset
            count   <= {1'b0, PRELOAD_RESET};
            dir_q   <= 1'b0;
        end else begin
            ab_prev <= ab_cur;

            if (step_up || step_dn)
                dir_q <= step_up;

            if (set)
                count <= {1'b0, preload};       // load wins over a step, clears ovf
            else if (step_up)
                count <= {count[24] | inc_sum[24], inc_sum[23:0]};
            else if (step_dn)
                count <= {count[24] | dec_diff[24], dec_diff[23:0]};
        end
    end

endmodule

/* hw/enc_period.sv */
/*
 * encoder velocity measurement
 *   running timer since the last A or B edge, saturating
 *   latest and four-back quarter periods, full period over four quarters
 *   direction tag in bit 31 of every result
 */

`timescale 1ns/1ps

module enc_period import enc_pkg::*; (
    input  logic      sysclk,
    input  logic      reset,   // sync, active low
    input  logic      a,       // filtered A
    input  logic      b,       // filtered B
    input  logic      dir,     // direction of the current step
    output enc_meas_t meas
);

    logic [1:0]  ab_prev;
    logic        trans;       // any edge on A or B
    logic [30:0] timer;       // cycles since last edge
    logic [30:0] interval;    // finished quarter period
    logic [30:0] hist [4];    // [0] newest .. [3] oldest
    logic [32:0] sum;         // four quarters, before saturation
    logic [30:0] perd_cnt;
    logic        dir_last;    // dir at the last edge

    assign trans = ({a, b} != ab_prev);

    // timer counts the cycle of the edge too
    assign interval = (timer == RUN_MAX) ? RUN_MAX : timer + 31'd1;

    // newest interval plus the three that stay in the history
    assign sum = 33'(interval) + 33'(hist[0]) + 33'(hist[1]) + 33'(hist[2]);

    // --------------------
    // timer
    // --------------------
    always_ff @(posedge sysclk) begin
        if (!reset) begin
            ab_prev <= 2'b00;
            timer   <= '0;
        end else begin
            ab_prev <= {a, b};
            if (trans)
                timer <= '0;              // restart at each edge
            else if (timer != RUN_MAX)
                timer <= timer + 31'd1;   // hold at max when stopped
        end
    end

    // --------------------
    // history and results
    // --------------------
    always_ff @(posedge sysclk) begin
        if (!reset) begin
            for (int i = 0; i < 4; i++)
                hist[i] <= '0;
            perd_cnt <= '0;
            dir_last <= 1'b0;
        end else if (trans) begin
            hist[0] <= interval;
            for (int i = 1; i < 4; i++)
                hist[i] <= hist[i-1];     // shift toward oldest
            perd_cnt <= (sum > {2'b00, RUN_MAX}) ? RUN_MAX : sum[30:0];
            dir_last <= dir;
        end
    end

    // all fields tagged with the same dir
    assign meas.perd = {dir_last, perd_cnt};
    assign meas.qtr1 = {dir_last, hist[0]};
    assign meas.qtr5 = {dir_last, hist[3]};
    assign meas.run  = {dir_last, timer};    // live

endmodule

/* hw/ctrl_enc.sv */
/*
 * encoder block top level
 *   per-channel line filters, position counters and period meters
 *   preload registers and one-cycle set pulses from register writes
 *   combinational read decode by channel and offset
 */

`timescale 1ns/1ps

module ctrl_enc import enc_pkg::*; (
    input  logic                    sysclk,
    input  logic                    reset,      // sync, active low
    input  logic [NUM_CHANNELS-1:0] enc_a,      // raw A lines, async
    input  logic [NUM_CHANNELS-1:0] enc_b,      // raw B lines, async
    input  logic [15:0]             reg_raddr,
    output logic [31:0]             reg_rdata,  // valid same cycle as raddr
    input  reg_wr_t                 wr
);

    // --------------------
    // local signals
    // --------------------
    logic [NUM_CHANNELS-1:0] enc_a_filt;
    logic [NUM_CHANNELS-1:0] enc_b_filt;
    logic [NUM_CHANNELS-1:0] dir;          // step direction per channel
    logic [NUM_CHANNELS-1:0] set_enc;      // preload strobe per channel

    logic [23:0]             preload    [NUM_CHANNELS];
    logic [24:0]             quad_count [NUM_CHANNELS];  // ovf in msb
    enc_meas_t               meas       [NUM_CHANNELS];

    // write side
    logic [3:0]              wr_chan;      // 1..4 on the bus
    logic [CH_W-1:0]         wr_idx;       // 0..3 internally
    logic                    load_hit;

    // read side
    logic [3:0]              rd_chan;
    logic [CH_W-1:0]         rd_idx;
    logic                    rd_ok;
    reg_offset_e             rd_off;

    // bus channel numbers start at 1
    function automatic logic chan_ok(input logic [3:0] ch);
        return (ch != 4'd0) && (ch <= 4'(NUM_CHANNELS));
    endfunction

    // --------------------
    // channel datapath
    // --------------------
    for (genvar i = 0; i < NUM_CHANNELS; i++) begin : g_chan
        enc_debounce i_filt_a (
            .sysclk (sysclk),
            .reset  (reset),
            .raw    (enc_a[i]),
            .filt   (enc_a_filt[i])
        );

        enc_debounce i_filt_b (
            .sysclk (sysclk),
            .reset  (reset),
            .raw    (enc_b[i]),
            .filt   (enc_b_filt[i])
        );

        // position
        enc_quad i_quad (
            .sysclk  (sysclk),
            .reset   (reset),
            .a       (enc_a_filt[i]),
            .b       (enc_b_filt[i]),
            .set     (set_enc[i]),
            .preload (preload[i]),
            .count   (quad_count[i]),
            .dir     (dir[i])
        );

        // velocity, 4/dT style
        enc_period i_period (
            .sysclk (sysclk),
            .reset  (reset),
            .a      (enc_a_filt[i]),
            .b      (enc_b_filt[i]),
            .dir    (dir[i]),
            .meas   (meas[i])
        );
    end

    // --------------------
    // preload writes
    // --------------------
    assign wr_chan  = wr.waddr[7:4];
    assign wr_idx   = CH_W'(wr_chan - 4'd1);
    assign load_hit = wr.wen && (wr.waddr[15:12] == ADDR_MAIN) &&
                      (reg_offset_e'(wr.waddr[3:0]) == OFF_ENC_LOAD) && chan_ok(wr_chan);

    always_ff @(posedge sysclk) begin
        if (!reset) begin
            set_enc <= '0;
            for (int i = 0; i < NUM_CHANNELS; i++)
                preload[i] <= PRELOAD_RESET;   // half scale
        end else begin
            set_enc <= '0;                     // strobe lasts one cycle
            if (load_hit) begin
                preload[wr_idx] <= wr.wdata[23:0];
                set_enc[wr_idx] <= 1'b1;
            end
        end
    end

    // --------------------
    // read decode
    // --------------------
    // no block select check here, upstream mux does that
    assign rd_chan = reg_raddr[7:4];
    assign rd_idx  = CH_W'(rd_chan - 4'd1);
    assign rd_ok   = chan_ok(rd_chan);
    assign rd_off  = reg_offset_e'(reg_raddr[3:0]);

    always_comb begin
        reg_rdata = '0;
        if (rd_ok) begin
            case (rd_off)
                OFF_ENC_LOAD:  reg_rdata = {8'd0, preload[rd_idx]};
                OFF_ENC_DATA:  reg_rdata = {7'd0, quad_count[rd_idx]};
                OFF_PER_DATA:  reg_rdata = meas[rd_idx].perd;
                OFF_QTR1_DATA: reg_rdata = meas[rd_idx].qtr1;
                OFF_QTR5_DATA: reg_rdata = meas[rd_idx].qtr5;
                OFF_RUN_DATA:  reg_rdata = meas[rd_idx].run;
                default:       reg_rdata = '0;  // unused offset
            endcase
        end
    end

endmodule

/* verification/tb_enc.sv */
/*
 * testbench for the encoder block
 *   clock, reset and trace file reader
 *   quadrature step and glitch stimulus, register reads and writes
 *   typed compare tasks, error counts and closing report
 */

`timescale 1ns/1ps

module tb_enc import enc_pkg::*; ();

    localparam int STEP_GAP        = 40;     // cycles between encoder edges
    localparam int GLITCH_GAP      = 10;     // quiet cycles after a glitch
    localparam int WAIT_LIMIT      = 2000;   // longest single wait
    localparam int WATCHDOG_CYCLES = 20000;
    localparam int MAX_LINES       = 500;

    logic                    sysclk;
    logic                    reset;
    logic [NUM_CHANNELS-1:0] enc_a;
    logic [NUM_CHANNELS-1:0] enc_b;
    logic [15:0]             reg_raddr;
    logic [31:0]             reg_rdata;
    reg_wr_t                 wr;

    logic [31:0] lfsr_state   = 32'h57945719;
    logic [31:0] run_mark     = '0;   // run value at the last mark read
    logic        done         = 1'b0;
    int          checks       = 0;
    int          value_errors = 0;
    int          other_errors = 0;

    ctrl_enc i_ctrl_enc (
        .sysclk    (sysclk),
        .reset     (reset),
        .enc_a     (enc_a),
        .enc_b     (enc_b),
        .reg_raddr (reg_raddr),
        .reg_rdata (reg_rdata),
        .wr        (wr)
    );

    initial sysclk = 1'b0;
    always #5 sysclk = ~sysclk;   // 10 ns period

    // --------------------
    // stimulus helpers
    // --------------------
    // forward order 00 -> 10 -> 11 -> 01, A leads B
    function automatic logic [1:0] next_ab(input logic [1:0] ab, input logic fwd);
        logic [1:0] nxt;
        case (ab)
            2'b00:   nxt = fwd ? 2'b10 : 2'b01;
            2'b10:   nxt = fwd ? 2'b11 : 2'b00;
            2'b11:   nxt = fwd ? 2'b01 : 2'b10;
            default: nxt = fwd ? 2'b00 : 2'b11;
        endcase
        return nxt;
    endfunction

    // fibonacci lfsr, taps 32 22 2 1, one step per bit
    function automatic logic [31:0] take_bits(input int nbits);
        logic        fb;
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < nbits; i++) begin
            fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            val        = {val[30:0], fb};
        end
        return val;
    endfunction

    // every task starts and ends 1 ns after a rising edge
    task automatic wait_cycles(input int n);
        int lim;
        lim = n;
        if (n > WAIT_LIMIT) begin
            other_errors++;
            $display("wait of %0d cycles is longer than the %0d cycle limit", n, WAIT_LIMIT);
            lim = WAIT_LIMIT;
        end
        for (int i = 0; i < lim; i++) begin
            @(posedge sysclk);
            #1;
        end
    endtask

    task automatic apply_steps(input int ch, input logic fwd, input int n);
        logic [1:0]      ab;
        logic [CH_W-1:0] idx;
        idx = CH_W'(ch - 1);
        if (ch < 1 || ch > NUM_CHANNELS) begin
            other_errors++;
            $display("step command names channel %0d, which does not exist", ch);
        end else begin
            for (int k = 0; k < n; k++) begin
                ab         = next_ab({enc_a[idx], enc_b[idx]}, fwd);
                enc_a[idx] = ab[1];
                enc_b[idx] = ab[0];
                wait_cycles(STEP_GAP);   // hold so every interval is exact
            end
        end
    endtask

    // short pulses on A only, never long enough for the filter
    task automatic apply_glitches(input int ch, input int n);
        logic [31:0]     w;
        logic [CH_W-1:0] idx;
        idx = CH_W'(ch - 1);
        if (ch < 1 || ch > NUM_CHANNELS) begin
            other_errors++;
            $display("glitch command names channel %0d, which does not exist", ch);
        end else begin
            for (int g = 0; g < n; g++) begin
                w          = take_bits(2);
                w          = (w % 32'd3) + 32'd1;   // 1..3 cycles
                enc_a[idx] = ~enc_a[idx];
                wait_cycles(int'(w));
                enc_a[idx] = ~enc_a[idx];
                wait_cycles(GLITCH_GAP);
            end
        end
    endtask

    task automatic write_reg(input logic [15:0] addr, input logic [31:0] data);
        wr.waddr = addr;
        wr.wdata = data;
        wr.wen   = 1'b1;
        @(posedge sysclk);   // write lands on this edge
        #1;
        wr.wen   = 1'b0;
    endtask

    // --------------------
    // compare tasks
    // --------------------
    task automatic check_count(input string name, input logic [24:0] expected,
                               input logic [24:0] actual);
        checks++;
        if (actual !== expected) begin
            value_errors++;
            $display("** Error %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic check_meas(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            value_errors++;
            $display("** Error %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic check_load(input string name, input logic [23:0] expected,
                              input logic [23:0] actual);
        checks++;
        if (actual !== expected) begin
            value_errors++;
            $display("** Error %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    // read takes one cycle, sampled mid cycle
    task automatic read_reg(input logic [15:0] addr, input byte kind,
                            input logic [31:0] expected, input string name);
        reg_raddr = addr;
        #3;
        case (kind)
            "C": check_count(name, expected[24:0], reg_rdata[24:0]);
            "L": check_load(name, expected[23:0], reg_rdata[23:0]);
            "M": check_meas(name, expected, reg_rdata);
            "T": run_mark = reg_rdata;                            // mark only
            "I": check_meas(name, expected, reg_rdata - run_mark); // growth since mark
            default: begin
                other_errors++;
                $display("unknown read kind in %s", name);
            end
        endcase
        @(posedge sysclk);
        #1;
    endtask

    // --------------------
    // main sequence
    // --------------------
    initial begin
        int          fd;
        int          lineno;
        int          nf;
        string       line;
        string       name;
        byte         cmd;
        byte         kind;
        logic [31:0] f1;
        logic [31:0] f2;
        logic [31:0] f3;

        reset     = 1'b0;
        enc_a     = '0;
        enc_b     = '0;
        reg_raddr = '0;
        wr        = '0;
        lineno    = 0;
        for (int i = 0; i < 16; i++)
            @(posedge sysclk);
        #1;
        reset = 1'b1;

        fd = $fopen("verification/enc_trace.txt", "r");
        if (fd == 0) begin
            other_errors++;
            $display("cannot open the trace file verification/enc_trace.txt");
        end else begin
            while (!$feof(fd) && lineno < MAX_LINES) begin
                line = "";
                nf   = $fgets(line, fd);
                lineno++;
                if (nf == 0 || line.len() == 0)
                    continue;
                cmd = line.getc(0);
                if (cmd == "#" || cmd == "\n")
                    continue;   // comment or blank
                name = $sformatf("line %0d", lineno);
                case (cmd)
                    "S": nf = $sscanf(line, "S %d %d %d", f1, f2, f3);
                    "G": nf = $sscanf(line, "G %d %d", f1, f2) + 1;
                    "W": nf = $sscanf(line, "W %h %h", f1, f2) + 1;
                    "R": nf = $sscanf(line, "R %h %c %h", f1, kind, f2);
                    "D": nf = $sscanf(line, "D %d", f1) + 2;
                    default: nf = 0;
                endcase
                if (nf != 3) begin
                    other_errors++;
                    $display("trace line %0d could not be understood", lineno);
                end else begin
                    case (cmd)
                        "S": apply_steps(int'(f1), f2[0], int'(f3));
                        "G": apply_glitches(int'(f1), int'(f2));
                        "W": write_reg(f1[15:0], f2);
                        "R": read_reg(f1[15:0], kind, f2,
                                      $sformatf("%s read %h", name, f1[15:0]));
                        default: wait_cycles(int'(f1));
                    endcase
                end
            end
            $fclose(fd);
        end

        if (checks == 0) begin
            other_errors++;
            $display("the trace held no checks");
        end
        done = 1'b1;
        $display("checks %0d, value errors %0d, other errors %0d",
                 checks, value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    // watchdog, whole run bounded
    initial begin
        for (int i = 0; i < WATCHDOG_CYCLES && !done; i++)
            @(posedge sysclk);
        if (!done) begin
            other_errors++;
            $display("run did not finish within %0d cycles", WATCHDOG_CYCLES);
            $display("checks %0d, value errors %0d, other errors %0d",
                     checks, value_errors, other_errors);
            $display("=== FAIL ===");
            $finish;
        end
    end

endmodule

/* filelist.f */
hw/enc_pkg.sv
hw/enc_debounce.sv
hw/enc_quad.sv
hw/enc_period.sv
hw/ctrl_enc.sv
verification/tb_enc.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the encoder block testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module tb_enc -f filelist.f -o sim_enc

sim_out=$(./obj_dir/sim_enc)
echo "$sim_out"

if grep -qx "=== PASS ===" <<< "$sim_out"; then
    exit 0
fi
exit 1

/* verification/enc_trace.txt */
# S ch dir n | G ch n | W addr data | R addr kind expected | D cycles   (numbers after R, W in hex)
# kinds: C count, L preload, M 32-bit word, T mark run, I run growth since mark
# after reset
R 4014 L 800000
R 4015 C 0800000
R 4016 M 00000000
R 4017 M 00000000
R 4018 M 00000000
R 4024 L 800000
R 4025 C 0800000
R 4034 L 800000
R 4035 C 0800000
R 4044 L 800000
R 4045 C 0800000
# preload on channel 2, count follows two cycles after the write
W 4024 00123456
R 4024 L 123456
R 4025 C 0123456
R 4015 C 0800000
R 4035 C 0800000
# wrong block select is ignored
W 5024 00abcdef
R 4024 L 123456
# channel 1 forward, intervals of 40 cycles
S 1 1 8
R 4015 C 0800008
R 4017 M 80000028
R 4018 M 80000028
R 4016 M 800000a0
R 4025 C 0123456
# run grows by the wait plus the read cycle
R 4019 T 0
D 25
R 4019 I 0000001a
# channel 1 reverse
S 1 0 8
R 4015 C 0800000
R 4017 M 00000028
R 4018 M 00000028
R 4016 M 000000a0
# glitches on channel 4 A
G 4 6
D 20
R 4045 C 0800000
R 4047 M 00000000
# overflow on channel 3
W 4034 00ffffff
S 3 1 1
R 4035 C 1000000
# invalid channel and unused offset
R 4005 M 00000000
R 4055 M 00000000
R 4013 M 00000000
R 401a M 00000000
